/* program.hex */
// One instruction word per line, loaded from word address 0, byte address = 2 * line
// Column 1 is the instruction in hex, the comment gives byte address and mnemonic
A135  // 00 LLB r1, 0x35
A20C  // 02 LLB r2, 0x0C
0312  // 04 ADD r3, r1, r2
1412  // 06 SUB r4, r1, r2
2512  // 08 XOR r5, r1, r2
4613  // 0A SLL r6, r1, 3
0711  // 0C ADD r7, r1, r1
0771  // 0E ADD r7, r7, r1    back-to-back
0877  // 10 ADD r8, r7, r7    memory stage wins over write-back
A901  // 12 LLB r9, 0x01
0A89  // 14 ADD r10, r8, r9   r8 two apart
AB40  // 16 LLB r11, 0x40
9AB1  // 18 SW  r10, 1(r11)
8CB1  // 1A LW  r12, 1(r11)
0DC9  // 1C ADD r13, r12, r9  load-use stall
1ECA  // 1E SUB r14, r12, r10 zero result, Z set
C201  // 20 B   EQ, +1        flag stall, then taken to 0x24
AFBD  // 22 LLB r15, 0xBD     skipped
C001  // 24 B   NEQ, +1       not taken
AF5A  // 26 LLB r15, 0x5A
E100  // 28 PCS r1            r1 = 0x2A
0219  // 2A ADD r2, r1, r9    PCS value forwarded
F000  // 2C HLT
AFEE  // 2E LLB r15, 0xEE     fetched behind HLT, never retires
AFEF  // 30 LLB r15, 0xEF

/* cpu.f */
design/cpuPkg.sv
design/pipeReg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/hazardUnit.sv
design/dataMemory.sv
design/cpu.sv
tb/cpuTb.sv

/* tb/cpuTb.sv */
module cpuTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numEntries  = 18;
  localparam int numTests    = 6;
  localparam int haltTimeout = 400;  // Cycles
  localparam int holdCycles  = 5;    // Cycles watched after hlt
  localparam int aluTest     = 0;
  localparam int fwdTest     = 1;
  localparam int memTest     = 2;
  localparam int branchTest  = 3;
  localparam int pcsTest     = 4;
  localparam int haltTest    = 5;
  localparam cpuPkg::word haltPc = 16'h002E;  // HLT at 0x2C, fetch stops one word past it

  logic           clk;
  logic           reset;
  logic           hlt;
  cpuPkg::word    pc;
  cpuPkg::wbTrace trace;

  cpuPkg::regId expRd      [numEntries];  // Expected retire order
  cpuPkg::word  expData    [numEntries];
  int           expTest    [numEntries];  // Owning test of each entry
  string        testName   [numTests];
  int           testErrors [numTests];
  int           fillIdx;
  int           traceIdx;                 // Next entry to match
  int           errorCount;
  int           testsPassed;
  int           testsFailed;
  logic         halted;

  cpu #(.romWords(256), .ramWords(256)) cpu_i (
    .clk   (clk),
    .reset (reset),
    .hlt   (hlt),
    .pc    (pc),
    .trace (trace)
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////
  // Expected write-back table
  //////////////////////////////////////////////////
  task automatic addExpected(input int test, input cpuPkg::regId rd, input cpuPkg::word data);
    expTest[fillIdx] = test;
    expRd[fillIdx]   = rd;
    expData[fillIdx] = data;
    fillIdx++;
  endtask

  task automatic fillTable();
    testName = '{"alu", "forwarding", "memory", "branch", "pcs", "halt"};
    fillIdx  = 0;
    addExpected(aluTest, 4'd1, 16'h0035);     // LLB
    addExpected(aluTest, 4'd2, 16'h000C);
    addExpected(aluTest, 4'd3, 16'h0041);     // 0x35 + 0x0C
    addExpected(aluTest, 4'd4, 16'h0029);     // 0x35 - 0x0C
    addExpected(aluTest, 4'd5, 16'h0039);     // 0x35 ^ 0x0C
    addExpected(aluTest, 4'd6, 16'h01A8);     // 0x35 << 3
    addExpected(fwdTest, 4'd7, 16'h006A);     // 0x35 + 0x35
    addExpected(fwdTest, 4'd7, 16'h009F);     // 0x6A + 0x35
    addExpected(fwdTest, 4'd8, 16'h013E);     // Newest r7 doubled
    addExpected(fwdTest, 4'd9, 16'h0001);
    addExpected(fwdTest, 4'd10, 16'h013F);    // 0x13E + 1
    addExpected(memTest, 4'd11, 16'h0040);    // Base address
    addExpected(memTest, 4'd12, 16'h013F);    // Loaded back from 0x42
    addExpected(memTest, 4'd13, 16'h0140);    // After the load-use stall
    addExpected(branchTest, 4'd14, 16'h0000); // Sets Z for the EQ branch
    addExpected(branchTest, 4'd15, 16'h005A); // Behind the not-taken NEQ
    addExpected(pcsTest, 4'd1, 16'h002A);     // PCS at 0x28
    addExpected(pcsTest, 4'd2, 16'h002B);     // 0x2A + 1
  endtask

  //////////////////////////////////////////////////
  // Result bookkeeping
  //////////////////////////////////////////////////
  task automatic finishTest(input int t);
    if (testErrors[t] == 0) begin
      $display("Test %s: pass", testName[t]);
      testsPassed++;
    end else begin
      $display("Test %s: fail, %0d errors", testName[t], testErrors[t]);
      testsFailed++;
    end
  endtask

  task automatic entryChecked(input logic ok);
    int t;
    if (trace.valid) begin  // Skips vacuous passes
      if (traceIdx >= numEntries) begin
        $display("Unexpected write-back r%0d = %h after the last expected entry",
                 trace.rd, trace.data);
        errorCount++;
      end else begin
        t = expTest[traceIdx];
        if (!ok) begin
          $display("MISMATCH %s: expected r%0d = %h, actual r%0d = %h", testName[t],
                   expRd[traceIdx], expData[traceIdx], trace.rd, trace.data);
          testErrors[t]++;
          errorCount++;
        end
        if ((traceIdx == numEntries - 1) || (expTest[traceIdx + 1] != t)) begin
          finishTest(t);  // Last entry of this test
        end
        traceIdx++;
      end
    end
  endtask

  task automatic haltFailed(input string what);
    $display("Halt check failed: %s", what);
    testErrors[haltTest]++;
    errorCount++;
  endtask

  task automatic waitForHalt(output logic seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && (cycles < haltTimeout)) begin
      @(negedge clk);  // Outputs settled mid-cycle
      seen = hlt;
      cycles++;
    end
  endtask

  //////////////////////////////////////////////////
  // Checks, sampled at the falling edge
  //////////////////////////////////////////////////
  traceOrder: assert property (@(negedge clk) disable iff (reset)
    trace.valid |-> ((traceIdx < numEntries) && (trace.rd == expRd[traceIdx]) &&
                     (trace.data == expData[traceIdx])))
    entryChecked(1'b1);
  else
    entryChecked(1'b0);

  haltLast: assert property (@(negedge clk) disable iff (reset)
    hlt |-> (traceIdx == numEntries))
    else haltFailed("hlt rose before all expected write-backs");

  haltQuiet: assert property (@(negedge clk) disable iff (reset) hlt |-> !trace.valid)
    else haltFailed("a write-back retired after HLT");

  haltSticky: assert property (@(negedge clk) disable iff (reset) hlt |=> hlt)
    else haltFailed("hlt dropped before reset");

  pcHeld: assert property (@(negedge clk) disable iff (reset)
    hlt |-> ($stable(pc) && (pc == haltPc)))
    else begin
      $display("MISMATCH halt: expected pc %h, actual pc %h", haltPc, pc);
      testErrors[haltTest]++;
      errorCount++;
    end

  //////////////////////////////////////////////////
  // Run
  //////////////////////////////////////////////////
  initial begin
    clk         = 1'b0;
    reset       = 1'b1;  // Held for 3 rising edges
    traceIdx    = 0;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    testErrors  = '{default: 0};
    fillTable();
    repeat (3) @(posedge clk);
    #5 reset = 1'b0;
    waitForHalt(halted);  // The program runs by itself
    if (halted) begin
      repeat (holdCycles) @(negedge clk);  // pc hold watched by the assertions
      #10;                                 // Last falling-edge checks complete
    end else begin
      $display("Timeout: the core never halted within %0d cycles", haltTimeout);
      testErrors[haltTest]++;
      errorCount++;
    end
    finishTest(haltTest);
    if (traceIdx < numEntries) begin
      $display("Only %0d of %0d expected write-backs appeared", traceIdx, numEntries);
      errorCount++;
    end
    $display("Summary: %0d passed, %0d failed, %0d not reached, %0d of %0d write-backs, %0d errors",
             testsPassed, testsFailed, numTests - testsPassed - testsFailed,
             traceIdx, numEntries, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* design/cpu.sv */
module cpu #(
  parameter int romWords = 256,
  parameter int ramWords = 256
) (
  input  logic           clk,
  input  logic           reset,
  output logic           hlt,    // HLT reached write-back
  output cpuPkg::word    pc,
  output cpuPkg::wbTrace trace   // Retire port
);

  cpuPkg::ifId  ifIdD;
  cpuPkg::ifId  ifIdQ;
  cpuPkg::idEx  idExD;
  cpuPkg::idEx  idExQ;
  cpuPkg::exMem exMemD;
  cpuPkg::exMem exMemQ;
  cpuPkg::memWb memWbD;
  cpuPkg::memWb memWbQ;

  cpuPkg::flags execFlags;
  cpuPkg::word  branchTarget;
  cpuPkg::word  memData;
  cpuPkg::word  wbData;
  cpuPkg::regId src1;
  cpuPkg::regId src2;
  logic         branchTaken;
  logic         isBranch;
  logic         halt;
  logic         stall;
  logic         bubble;
  logic         branchFlush;

  //////////////////////////////////////////////////
  // Fetch and decode
  //////////////////////////////////////////////////
  fetch #(.romWords(romWords)) fetch_i (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .halt         (halt),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .pc           (pc),
    .ifOut        (ifIdD)
  );

  pipeReg #(.payload(cpuPkg::ifId)) ifIdReg (
    .clk(clk), .reset(reset), .stall(stall), .flush(branchFlush), .d(ifIdD), .q(ifIdQ)
  );

  decode decode_i (
    .clk          (clk),
    .reset        (reset),
    .idIn         (ifIdQ),
    .execFlags    (execFlags),
    .wbWrite      (memWbQ.regWrite),
    .wbRd         (memWbQ.rd),
    .wbData       (wbData),
    .idOut        (idExD),
    .isBranch     (isBranch),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .halt         (halt),
    .src1         (src1),
    .src2         (src2)
  );

  hazardUnit hazard_i (
    .src1        (src1),
    .src2        (src2),
    .isBranch    (isBranch),
    .branchTaken (branchTaken),
    .exRd        (idExQ.rd),
    .exMemRead   (idExQ.memRead),
    .exSetsFlags (idExQ.setsFlags),
    .stall       (stall),
    .bubble      (bubble),
    .branchFlush (branchFlush)
  );

  pipeReg #(.payload(cpuPkg::idEx)) idExReg (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(bubble), .d(idExD), .q(idExQ)
  );

  //////////////////////////////////////////////////
  // Execute and memory
  //////////////////////////////////////////////////
  execute execute_i (
    .clk       (clk),
    .reset     (reset),
    .exIn      (idExQ),
    .memFwd    (exMemQ),
    .wbFwd     (memWbQ),
    .wbData    (wbData),
    .exOut     (exMemD),
    .execFlags (execFlags)
  );

  pipeReg #(.payload(cpuPkg::exMem)) exMemReg (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
  );

  dataMemory #(.ramWords(ramWords)) dataMemory_i (
    .clk       (clk),
    .reset     (reset),
    .addr      (exMemQ.aluOut),
    .writeData (exMemQ.storeData),
    .read      (exMemQ.memRead),
    .write     (exMemQ.memWrite),
    .readData  (memData)
  );

  assign memWbD = '{
    aluOut:   exMemQ.aluOut,
    memData:  memData,
    pcNext:   exMemQ.pcNext,
    regWrite: exMemQ.regWrite,
    memToReg: exMemQ.memToReg,
    isPcs:    exMemQ.isPcs,
    isHlt:    exMemQ.isHlt,
    rd:       exMemQ.rd
  };

  pipeReg #(.payload(cpuPkg::memWb)) memWbReg (
    .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
  );

  //////////////////////////////////////////////////
  // Write-back
  //////////////////////////////////////////////////
  assign wbData = memWbQ.memToReg ? memWbQ.memData :  // LW
                  memWbQ.isPcs    ? memWbQ.pcNext  :  // PCS
                                    memWbQ.aluOut;

  assign hlt   = memWbQ.isHlt;  // Decode keeps issuing HLT once seen
  assign trace = '{valid: memWbQ.regWrite, rd: memWbQ.rd, data: wbData};

endmodule

/* design/dataMemory.sv */
module dataMemory #(
  parameter int ramWords = 256
) (
  input  logic        clk,
  input  logic        reset,
  input  cpuPkg::word addr,
  input  cpuPkg::word writeData,
  input  logic        read,
  input  logic        write,
  output cpuPkg::word readData
);

  localparam int idxW = $clog2(ramWords);

  cpuPkg::word      ram [ramWords];
  logic [idxW-1:0]  index;  // Word index

  assign index = addr[idxW:1];  // Bit 0 selects a byte, unused

  always_ff @(posedge clk) begin
    if (write && !reset) begin
      ram[index] <= writeData;
    end
  end

  assign readData = read ? ram[index] : '0;  // Same-cycle read

  oneAccess: assert property (@(posedge clk) disable iff (reset) !(read && write))
    else $error("dataMemory: read and write together at %h", addr);

endmodule

/* design/hazardUnit.sv */
module hazardUnit (
  input  cpuPkg::regId src1,         // Sources of the instruction in decode
  input  cpuPkg::regId src2,
  input  logic         isBranch,
  input  logic         branchTaken,
  input  cpuPkg::regId exRd,         // Destination of the instruction in execute
  input  logic         exMemRead,
  input  logic         exSetsFlags,
  output logic         stall,        // Hold pc and ifId
  output logic         bubble,       // Clear idEx
  output logic         branchFlush   // Clear the wrong fetch
);

  logic loadUse;
  logic flagWait;

  // Load result exists only after memory, so the consumer waits one cycle
  assign loadUse = exMemRead && (exRd != '0) &&
                   ((exRd == src1) || (exRd == src2));

  // Branch reads the flag register, which updates at the end of execute
  assign flagWait = isBranch && exSetsFlags;

  assign stall  = loadUse || flagWait;
  assign bubble = stall;  // One bubble per held cycle

  assign branchFlush = branchTaken && !stall;  // A stalled branch decides next cycle

endmodule

/* design/execute.sv */
module execute (
  input  logic          clk,
  input  logic          reset,
  input  cpuPkg::idEx   exIn,
  input  cpuPkg::exMem  memFwd,     // Instruction now in memory
  input  cpuPkg::memWb  wbFwd,      // Instruction now in write-back
  input  cpuPkg::word   wbData,     // Its selected write data
  output cpuPkg::exMem  exOut,
  output cpuPkg::flags  execFlags   // Flag register
);

  cpuPkg::word memValue;  // What the memory-stage instruction will write
  cpuPkg::word opA;
  cpuPkg::word storeVal;  // Forwarded second register
  cpuPkg::word opB;
  cpuPkg::word result;
  logic        fwdMem1;
  logic        fwdMem2;
  logic        fwdWb1;
  logic        fwdWb2;
  logic        overflow;

  //////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////
  assign memValue = memFwd.isPcs ? memFwd.pcNext : memFwd.aluOut;

  assign fwdMem1 = memFwd.regWrite && (memFwd.rd == exIn.src1);
  assign fwdMem2 = memFwd.regWrite && (memFwd.rd == exIn.src2);
  assign fwdWb1  = wbFwd.regWrite && (wbFwd.rd == exIn.src1);
  assign fwdWb2  = wbFwd.regWrite && (wbFwd.rd == exIn.src2);

  assign opA      = fwdMem1 ? memValue : fwdWb1 ? wbData : exIn.data1;  // Newest wins
  assign storeVal = fwdMem2 ? memValue : fwdWb2 ? wbData : exIn.data2;
  assign opB      = exIn.useImm ? exIn.imm : storeVal;

  //////////////////////////////////////////////////
  // ALU and flags
  //////////////////////////////////////////////////
  always_comb begin
    overflow = 1'b0;
    case (exIn.op)
      cpuPkg::aluAdd: begin
        result   = opA + opB;
        overflow = (opA[15] == opB[15]) && (result[15] != opA[15]);
      end
      cpuPkg::aluSub: begin
        result   = opA - opB;
        overflow = (opA[15] != opB[15]) && (result[15] != opA[15]);
      end
      cpuPkg::aluXor: result = opA ^ opB;
      default:        result = opA << opB[3:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      execFlags <= '0;
    end else if (exIn.setsFlags) begin
      execFlags.z <= (result == '0);
      if ((exIn.op == cpuPkg::aluAdd) || (exIn.op == cpuPkg::aluSub)) begin
        execFlags.n <= result[15];
        execFlags.v <= overflow;
      end else if (exIn.op == cpuPkg::aluXor) begin
        execFlags.n <= result[15];  // V untouched by XOR
      end
    end
  end

  always_comb begin
    exOut.aluOut    = result;
    exOut.storeData = storeVal;
    exOut.pcNext    = exIn.pcNext;
    exOut.memRead   = exIn.memRead;
    exOut.memWrite  = exIn.memWrite;
    exOut.regWrite  = exIn.regWrite;
    exOut.memToReg  = exIn.memToReg;
    exOut.isPcs     = exIn.isPcs;
    exOut.isHlt     = exIn.isHlt;
    exOut.rd        = exIn.rd;
  end

  // Load data is not ready in memory stage, the hazard unit must have stalled
  noLoadForward: assert property (@(posedge clk) disable iff (reset)
    !(memFwd.memRead && (fwdMem1 || fwdMem2)))
    else $error("execute: forward from load r%0d in memory stage", memFwd.rd);

endmodule

/* design/decode.sv */
module decode (
  input  logic              clk,
  input  logic              reset,
  input  cpuPkg::ifId       idIn,
  input  cpuPkg::flags      execFlags,     // Flag register of execute
  input  logic              wbWrite,
  input  cpuPkg::regId      wbRd,
  input  cpuPkg::word       wbData,
  output cpuPkg::idEx       idOut,
  output logic              isBranch,
  output logic              branchTaken,
  output cpuPkg::word       branchTarget,
  output logic              halt,
  output cpuPkg::regId      src1,
  output cpuPkg::regId      src2
);

  cpuPkg::word       regs [16];  // Register file, r0 never written
  cpuPkg::opcode     opc;
  cpuPkg::branchCond cond;
  cpuPkg::idEx       ctl;        // Control and fields before register data
  cpuPkg::word       rdData1;
  cpuPkg::word       rdData2;
  logic              valid;      // ifId holds a real instruction
  logic              haltSeen;   // HLT already passed decode
  logic              condMet;

  assign valid = (idIn.pcNext != '0);  // Real fetches always carry pc+2
  assign opc   = cpuPkg::opcode'(idIn.inst[15:12]);
  assign cond  = cpuPkg::branchCond'(idIn.inst[11:9]);

  //////////////////////////////////////////////////
  // Register file with write-through
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wbWrite && (wbRd != '0)) begin
      regs[wbRd] <= wbData;
    end
  end

  assign rdData1 = (src1 == '0) ? '0 : (wbWrite && (wbRd == src1)) ? wbData : regs[src1];
  assign rdData2 = (src2 == '0) ? '0 : (wbWrite && (wbRd == src2)) ? wbData : regs[src2];

  //////////////////////////////////////////////////
  // Control generation
  //////////////////////////////////////////////////
  always_comb begin
    ctl        = '0;
    src1       = '0;
    src2       = '0;
    isBranch   = 1'b0;
    ctl.pcNext = idIn.pcNext;
    ctl.rd     = idIn.inst[11:8];
    if (valid) begin
      case (opc)
        cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opXor: begin
          src1          = idIn.inst[7:4];
          src2          = idIn.inst[3:0];
          ctl.regWrite  = 1'b1;
          ctl.setsFlags = 1'b1;
          ctl.op        = (opc == cpuPkg::opAdd) ? cpuPkg::aluAdd :
                          (opc == cpuPkg::opSub) ? cpuPkg::aluSub : cpuPkg::aluXor;
        end
        cpuPkg::opSll: begin
          src1          = idIn.inst[7:4];
          ctl.imm       = {12'h000, idIn.inst[3:0]};  // Shift amount
          ctl.useImm    = 1'b1;
          ctl.regWrite  = 1'b1;
          ctl.setsFlags = 1'b1;
          ctl.op        = cpuPkg::aluSll;
        end
        cpuPkg::opLw, cpuPkg::opSw: begin
          src1         = idIn.inst[7:4];                           // Base register
          src2         = (opc == cpuPkg::opSw) ? idIn.inst[11:8] : '0;  // Store data
          ctl.imm      = {{11{idIn.inst[3]}}, idIn.inst[3:0], 1'b0};  // Word offset
          ctl.useImm   = 1'b1;
          ctl.memRead  = (opc == cpuPkg::opLw);
          ctl.memWrite = (opc == cpuPkg::opSw);
          ctl.regWrite = (opc == cpuPkg::opLw);
          ctl.memToReg = (opc == cpuPkg::opLw);
        end
        cpuPkg::opLlb: begin
          ctl.imm      = {8'h00, idIn.inst[7:0]};  // r0 + imm8
          ctl.useImm   = 1'b1;
          ctl.regWrite = 1'b1;
        end
        cpuPkg::opB: isBranch = 1'b1;
        cpuPkg::opPcs: begin
          ctl.regWrite = 1'b1;
          ctl.isPcs    = 1'b1;
        end
        cpuPkg::opHlt: ctl.isHlt = 1'b1;
        default: ;  // Unused opcodes retire as nops
      endcase
    end
    if (ctl.rd == '0) begin
      ctl.regWrite = 1'b0;  // Writes to r0 vanish here, no forward, no trace
    end
    if (haltSeen) begin
      ctl.isHlt = 1'b1;  // Keep HLT flowing so it stays in write-back
    end
    ctl.src1 = src1;
    ctl.src2 = src2;
  end

  always_comb begin
    idOut       = ctl;
    idOut.data1 = rdData1;
    idOut.data2 = rdData2;
  end

  assign halt = ctl.isHlt;

  always_ff @(posedge clk) begin
    if (reset) begin
      haltSeen <= 1'b0;
    end else if (halt) begin
      haltSeen <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Branch resolution
  //////////////////////////////////////////////////
  always_comb begin
    case (cond)
      cpuPkg::condNeq: condMet = !execFlags.z;
      cpuPkg::condEq:  condMet = execFlags.z;
      cpuPkg::condGt:  condMet = !execFlags.z && !execFlags.n;
      cpuPkg::condLt:  condMet = execFlags.n;
      cpuPkg::condGte: condMet = execFlags.z || (!execFlags.z && !execFlags.n);
      cpuPkg::condLte: condMet = execFlags.n || execFlags.z;
      cpuPkg::condOvf: condMet = execFlags.v;
      default:         condMet = 1'b1;  // Unconditional
    endcase
  end

  assign branchTaken  = isBranch && condMet;
  assign branchTarget = idIn.pcNext + {{6{idIn.inst[8]}}, idIn.inst[8:0], 1'b0};

endmodule

/* design/fetch.sv */
module fetch #(
  parameter int romWords = 256
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         stall,         // Hazard hold
  input  logic         halt,          // HLT decoded, freeze from now on
  input  logic         branchTaken,
  input  cpuPkg::word  branchTarget,
  output cpuPkg::word  pc,
  output cpuPkg::ifId  ifOut
);

  localparam int romIdxW = $clog2(romWords);

  cpuPkg::word rom [romWords];  // Instruction ROM, one word per entry
  cpuPkg::word pcPlus2;         // Sequential next address
  cpuPkg::word inst;            // Word at pc

  initial begin
    $readmemh("program.hex", rom);
  end

  assign pcPlus2 = pc + 16'd2;
  assign inst    = rom[pc[romIdxW:1]];  // Word index, bit 0 is the byte offset

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= cpuPkg::resetPc;
    end else if (!(stall || halt)) begin
      pc <= branchTaken ? branchTarget : pcPlus2;  // Predict not taken, fix in decode
    end
  end

  always_comb begin
    ifOut.pcNext = pcPlus2;
    ifOut.inst   = inst;
    if (halt) begin
      ifOut = '0;  // Nothing past HLT enters decode
    end
  end

  // Offsets are shifted left by one, so a fetch address is never odd
  pcEven: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
    else $error("fetch: odd pc %h", pc);

endmodule

/* design/pipeReg.sv */
module pipeReg #(
  parameter type payload = logic
) (
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,  // Keep current contents
  input  logic   flush,  // Load a bubble
  input  payload d,
  output payload q
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;  // All control bits low
    end else if (!stall) begin
      q <= d;
    end
  end

  // Hazard unit never asks to hold and clear the same stage
  holdOrClear: assert property (@(posedge clk) disable iff (reset) !(stall && flush))
    else $error("pipeReg: stall and flush together");

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

  typedef logic [15:0] word;   // Data and address width
  typedef logic [3:0]  regId;  // Register number, r0 reads zero

  //////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    opAdd = 4'h0,  // rd = rs + rt
    opSub = 4'h1,  // rd = rs - rt
    opXor = 4'h2,  // rd = rs ^ rt
    opSll = 4'h4,  // rd = rs << imm4
    opLw  = 4'h8,  // rt = mem[rs + off4*2]
    opSw  = 4'h9,  // mem[rs + off4*2] = rt
    opLlb = 4'hA,  // rd = zero-extended imm8
    opB   = 4'hC,  // Conditional branch, ccc + off9
    opPcs = 4'hE,  // rd = address of PCS plus 2
    opHlt = 4'hF   // Stop fetching
  } opcode;

  typedef enum logic [2:0] {
    condNeq    = 3'b000,  // Z clear
    condEq     = 3'b001,  // Z set
    condGt     = 3'b010,  // Z and N clear
    condLt     = 3'b011,  // N set
    condGte    = 3'b100,  // Z set, or Z and N clear
    condLte    = 3'b101,  // N or Z set
    condOvf    = 3'b110,  // V set
    condUncond = 3'b111   // Always
  } branchCond;

  typedef struct packed {
    logic z;  // Zero
    logic v;  // Signed overflow
    logic n;  // Negative
  } flags;

  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluXor,
    aluSll
  } aluOp;

  //////////////////////////////////////////////////
  // Pipeline register payloads, all-zero is a bubble
  //////////////////////////////////////////////////
  typedef struct packed {
    word pcNext;  // Fetch address plus 2, zero marks a bubble
    word inst;
  } ifId;

  typedef struct packed {
    regId src1;       // First source, zero when unused
    regId src2;       // Second source or store data register
    word  data1;
    word  data2;
    word  imm;
    aluOp op;
    logic useImm;     // Operand B from imm
    logic setsFlags;
    logic memRead;
    logic memWrite;
    logic regWrite;   // Never set for r0
    logic memToReg;
    logic isPcs;
    logic isHlt;
    regId rd;
    word  pcNext;
  } idEx;

  typedef struct packed {
    word  aluOut;     // Result or memory address
    word  storeData;
    word  pcNext;
    logic memRead;
    logic memWrite;
    logic regWrite;
    logic memToReg;
    logic isPcs;
    logic isHlt;
    regId rd;
  } exMem;

  typedef struct packed {
    word  aluOut;
    word  memData;
    word  pcNext;
    logic regWrite;
    logic memToReg;
    logic isPcs;
    logic isHlt;
    regId rd;
  } memWb;

  typedef struct packed {
    logic valid;  // A register write retired this cycle
    regId rd;
    word  data;
  } wbTrace;

  localparam word resetPc = 16'h0000;  // First fetch address

endpackage
